/* eth_mac_fifo.f */
hw/eth_mac_pkg.sv
hw/byte_stream_if.sv
hw/frame_fifo.sv
hw/eth_mac_tx.sv
hw/eth_mac_rx.sv
hw/eth_mac_fifo.sv
sim/eth_mac_fifo_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module eth_mac_fifo_tb --Mdir obj_dir \
        -f eth_mac_fifo.f > "$BUILD_LOG" 2>&1; then
    cat "$BUILD_LOG"
    echo "Build failed"
    exit 1
fi

./obj_dir/Veth_mac_fifo_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ "$sim_status" -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
fi

if grep -q "Verification passed" "$SIM_LOG"; then
    exit 0
fi
exit 1

/* sim/eth_mac_fifo_tb.sv */
// Ethernet MAC loopback testbench
module eth_mac_fifo_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MIN_FRAME_LEN = 64;
    localparam int TX_FIFO_DEPTH = 128;
    localparam int RX_FIFO_DEPTH = 256;
    localparam int MIN_DATA_LEN  = MIN_FRAME_LEN - 4;  // Shortest payload after padding.
    localparam int TIMEOUT       = 5000;

    typedef struct {
        string      name;
        int         len;
        int         frames;
        bit         tx_bad;
        bit         corrupt;
        bit         rx_er;
        bit         rx_en;
        int         ifg;
        int         rx_frames;
        logic [7:0] status;   // Outputs that pulse once per frame, in the bit order of status_now.
    } test_t;

    logic       logic_clk;
    logic       logic_rst;
    logic [7:0] s_tx_data;
    logic       s_tx_valid;
    logic       s_tx_ready;
    logic       s_tx_last;
    logic       s_tx_user;
    logic [7:0] m_rx_data;
    logic       m_rx_valid;
    logic       m_rx_ready;
    logic       m_rx_last;
    logic       m_rx_user;
    logic [7:0] gmii_txd;
    logic       gmii_tx_en;
    logic       gmii_tx_er;
    logic [7:0] gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    logic [7:0] cfg_ifg;
    logic       cfg_tx_enable;
    logic       cfg_rx_enable;
    logic [7:0] status_now;

    test_t      tests [$];
    logic [7:0] exp_data_q [$];
    logic       exp_last_q [$];
    logic [7:0] rx_data_q [$];
    logic       rx_last_q [$];
    logic [31:0] lcg_state;
    string      cur_name;
    int         error_count;
    int         pulse_count [8];
    int         tx_en_cycles;
    int         tx_byte_idx;    // Wire byte index inside the current frame.
    int         low_run;
    int         last_gap;
    bit         corrupt_armed;
    int         corrupt_at;
    bit [7:0]   corrupt_mask;

    eth_mac_fifo #(
        .MIN_FRAME_LEN(MIN_FRAME_LEN),
        .TX_FIFO_DEPTH(TX_FIFO_DEPTH),
        .RX_FIFO_DEPTH(RX_FIFO_DEPTH)
    ) DUT (
        .logic_clk(logic_clk), .logic_rst(logic_rst),
        .s_tx_data(s_tx_data), .s_tx_valid(s_tx_valid), .s_tx_ready(s_tx_ready),
        .s_tx_last(s_tx_last), .s_tx_user(s_tx_user),
        .m_rx_data(m_rx_data), .m_rx_valid(m_rx_valid), .m_rx_ready(m_rx_ready),
        .m_rx_last(m_rx_last), .m_rx_user(m_rx_user),
        .gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er),
        .gmii_rxd(gmii_rxd), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er),
        .cfg_ifg(cfg_ifg), .cfg_tx_enable(cfg_tx_enable), .cfg_rx_enable(cfg_rx_enable),
        .tx_fifo_overflow(status_now[7]), .tx_fifo_bad_frame(status_now[6]),
        .tx_fifo_good_frame(status_now[5]), .rx_error_bad_frame(status_now[4]),
        .rx_error_bad_fcs(status_now[3]), .rx_fifo_overflow(status_now[2]),
        .rx_fifo_bad_frame(status_now[1]), .rx_fifo_good_frame(status_now[0])
    );

    // The wire is looped back, with one byte flipped when a test asks for it.
    assign gmii_rxd   = gmii_txd ^ corrupt_mask;
    assign gmii_rx_dv = gmii_tx_en;

    initial begin
        logic_clk = 1'b0;
        forever #20 logic_clk = ~logic_clk;
    end

    // ##################################################
    // Checks and monitors
    // ##################################################

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
            error_count++;
            $display("Verification failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "Stopped on a timeout");
    endtask

    always @(posedge logic_clk) begin
        if (!logic_rst) begin
            for (int i = 0; i < 8; i++) begin
                if (status_now[i]) begin
                    pulse_count[i] <= pulse_count[i] + 1;
                end
            end
            if (gmii_tx_en) begin
                tx_en_cycles <= tx_en_cycles + 1;
                tx_byte_idx  <= tx_byte_idx + 1;
                if (low_run != 0) begin
                    last_gap <= low_run;  // Idle cycles ahead of this frame.
                end
                low_run <= 0;
            end else begin
                tx_byte_idx <= 0;
                low_run     <= low_run + 1;
            end
            check_value({cur_name, " gmii_tx_er"}, 32'd0, 32'(gmii_tx_er));
            if (m_rx_valid && m_rx_ready) begin
                rx_data_q.push_back(m_rx_data);
                rx_last_q.push_back(m_rx_last);
                if (m_rx_last) begin
                    check_value({cur_name, " m_rx_user"}, 32'd0, 32'(m_rx_user));
                end
            end
        end
    end

    always @(negedge logic_clk) begin
        corrupt_mask <= (corrupt_armed && gmii_tx_en && tx_byte_idx == corrupt_at) ? 8'h40 : 8'h00;
    end

    initial begin
        repeat (400000) @(posedge logic_clk);
        stop_with_failure("Simulation ran past its overall cycle limit");
    end

    // ##################################################
    // Stimulus
    // ##################################################

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_test(input string name, input int len, input int frames,
                            input bit tx_bad, input bit corrupt, input bit rx_er,
                            input bit rx_en, input int ifg, input int rx_frames,
                            input logic [7:0] status);
        test_t t;
        t = '{name, len, frames, tx_bad, corrupt, rx_er, rx_en, ifg, rx_frames, status};
        tests.push_back(t);
    endtask

    // Sends one frame and queues what the receiver should return, padding included.
    task automatic send_frame(input int len, input bit bad);
        logic [7:0] b;
        int         waited;
        for (int i = 0; i < len; i++) begin
            lcg_state = lcg_next(lcg_state);
            b = lcg_state[23:16];
            exp_data_q.push_back(b);
            exp_last_q.push_back(1'b0);
            @(negedge logic_clk);
            s_tx_data  = b;
            s_tx_valid = 1'b1;
            s_tx_last  = (i == len - 1);
            s_tx_user  = bad && (i == len - 1);
            waited = 0;
            while (!s_tx_ready) begin
                @(negedge logic_clk);
                waited++;
                if (waited > TIMEOUT) begin
                    stop_with_failure("TX stream never became ready");
                end
            end
        end
        for (int i = len; i < MIN_DATA_LEN; i++) begin
            exp_data_q.push_back(8'h00);
            exp_last_q.push_back(1'b0);
        end
        exp_last_q[exp_last_q.size() - 1] = 1'b1;
        @(negedge logic_clk);
        s_tx_valid = 1'b0;
        s_tx_last  = 1'b0;
        s_tx_user  = 1'b0;
    endtask

    task automatic wait_rx_bytes(input int base, input int count);
        int waited;
        waited = 0;
        while (rx_data_q.size() - base < count) begin
            @(negedge logic_clk);
            waited++;
            if (waited > 4 * TIMEOUT) begin
                stop_with_failure("Received frame did not arrive in time");
            end
        end
    endtask

    // Waits until neither the wire nor the RX stream has moved for a number of cycles.
    task automatic wait_quiet(input int cycles);
        int quiet;
        int waited;
        quiet  = 0;
        waited = 0;
        while (quiet < cycles) begin
            @(negedge logic_clk);
            quiet = (gmii_tx_en || m_rx_valid) ? 0 : quiet + 1;
            waited++;
            if (waited > cycles + 4 * TIMEOUT) begin
                stop_with_failure("Wire and RX stream never went quiet");
            end
        end
    endtask

    task automatic run_test(input test_t t);
        int         base_pulse [8];
        int         base_tx;
        int         base_rx;
        int         padded;
        int         exp_tx;
        cur_name = t.name;
        exp_data_q.delete();
        exp_last_q.delete();
        padded = (t.len > MIN_DATA_LEN) ? t.len : MIN_DATA_LEN;
        @(negedge logic_clk);
        cfg_ifg       = 8'(t.ifg);
        cfg_rx_enable = t.rx_en;
        gmii_rx_er    = t.rx_er;   // Level held through the whole frame.
        corrupt_armed = t.corrupt;
        corrupt_at    = 8 + t.len / 2;  // Preamble and SFD come first.
        base_tx       = tx_en_cycles;
        base_rx       = rx_data_q.size();
        base_pulse    = pulse_count;
        for (int f = 0; f < t.frames; f++) begin
            send_frame(t.len, t.tx_bad);
        end
        if (t.rx_frames > 0) begin
            wait_rx_bytes(base_rx, t.rx_frames * padded);
            wait_quiet(50);
        end else begin
            wait_quiet(2000);
        end
        gmii_rx_er    = 1'b0;
        corrupt_armed = 1'b0;

        // Bad and oversize frames never reach the wire.
        exp_tx = (!t.tx_bad && t.len <= TX_FIFO_DEPTH) ? t.frames * (8 + padded + 4) : 0;
        check_value({t.name, " tx_en cycles"}, exp_tx, tx_en_cycles - base_tx);
        check_value({t.name, " rx bytes"}, t.rx_frames * padded, rx_data_q.size() - base_rx);
        if (t.rx_frames > 0) begin
            for (int i = 0; i < exp_data_q.size(); i++) begin
                check_value({t.name, " rx data"}, 32'(exp_data_q[i]),
                            32'(rx_data_q[base_rx + i]));
                check_value({t.name, " rx last"}, 32'(exp_last_q[i]),
                            32'(rx_last_q[base_rx + i]));
            end
        end
        // Each status output is high for one cycle per frame, or not at all.
        for (int i = 0; i < 8; i++) begin
            check_value($sformatf("%s status pulses %0d", t.name, i),
                        32'(t.status[i] ? t.frames : 0),
                        32'(pulse_count[i] - base_pulse[i]));
        end
        if (t.frames > 1) begin
            check_value({t.name, " gap long enough"}, 32'd1, 32'(last_gap >= t.ifg));
        end
        $display("Test %s done", t.name);
    endtask

    // ##################################################
    // Test table and main sequence
    // ##################################################

    initial begin
        logic_rst     = 1'b1;
        s_tx_data     = 8'h00;
        s_tx_valid    = 1'b0;
        s_tx_last     = 1'b0;
        s_tx_user     = 1'b0;
        m_rx_ready    = 1'b1;
        gmii_rx_er    = 1'b0;
        cfg_ifg       = 8'd12;
        cfg_tx_enable = 1'b1;
        cfg_rx_enable = 1'b1;
        corrupt_armed = 1'b0;
        corrupt_at    = 0;
        corrupt_mask  = 8'h00;
        error_count   = 0;
        cur_name      = "reset";
        lcg_state     = 32'h0b83_a3f1;

        // Columns are name, length, frames, tx bad, corrupt, rx_er, rx enable, ifg,
        // received frames and status pulses.
        add_test("good_70",        70,  1, 0, 0, 0, 1, 12, 1, 8'b0010_0001);
        add_test("good_100",       100, 1, 0, 0, 0, 1, 12, 1, 8'b0010_0001);
        add_test("good_127",       127, 1, 0, 0, 0, 1, 12, 1, 8'b0010_0001);
        add_test("short_1",        1,   1, 0, 0, 0, 1, 12, 1, 8'b0010_0001);
        add_test("short_20",       20,  1, 0, 0, 0, 1, 12, 1, 8'b0010_0001);
        add_test("short_59",       59,  1, 0, 0, 0, 1, 12, 1, 8'b0010_0001);
        add_test("tx_user_bad",    80,  1, 1, 0, 0, 1, 12, 0, 8'b0100_0000);
        add_test("fcs_error",      90,  1, 0, 1, 0, 1, 12, 0, 8'b0010_1010);
        add_test("rx_er_frame",    90,  1, 0, 0, 1, 1, 12, 0, 8'b0011_0010);
        add_test("oversize_200",   200, 1, 0, 0, 0, 1, 12, 0, 8'b1000_0000);
        add_test("after_oversize", 100, 1, 0, 0, 0, 1, 12, 1, 8'b0010_0001);
        add_test("rx_disabled",    70,  1, 0, 0, 0, 0, 12, 0, 8'b0010_0000);
        add_test("ifg_20_pair",    50,  2, 0, 0, 0, 1, 20, 2, 8'b0010_0001);

        repeat (10) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;

        foreach (tests[i]) begin
            run_test(tests[i]);
        end

        if (error_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "Errors were counted");
        end
    end

endmodule

/* hw/eth_mac_fifo.sv */
// Ethernet MAC with frame FIFOs
module eth_mac_fifo #(
    parameter int MIN_FRAME_LEN = 64,
    parameter int TX_FIFO_DEPTH = 256,
    parameter int RX_FIFO_DEPTH = 256
) (
    input  logic       logic_clk,
    input  logic       logic_rst,

    // ##################################################
    // User streams
    // ##################################################
    input  logic [7:0] s_tx_data,
    input  logic       s_tx_valid,
    output logic       s_tx_ready,
    input  logic       s_tx_last,
    input  logic       s_tx_user,
    output logic [7:0] m_rx_data,
    output logic       m_rx_valid,
    input  logic       m_rx_ready,
    output logic       m_rx_last,
    output logic       m_rx_user,

    // ##################################################
    // GMII, configuration and status
    // ##################################################
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er,
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    input  logic [7:0] cfg_ifg,
    input  logic       cfg_tx_enable,
    input  logic       cfg_rx_enable,
    output logic       tx_fifo_overflow,
    output logic       tx_fifo_bad_frame,
    output logic       tx_fifo_good_frame,
    output logic       rx_error_bad_frame,
    output logic       rx_error_bad_fcs,
    output logic       rx_fifo_overflow,
    output logic       rx_fifo_bad_frame,
    output logic       rx_fifo_good_frame
);

    byte_stream_if s_tx_if ();
    byte_stream_if s_tx_fifo_out ();
    byte_stream_if rx_mac_out ();
    byte_stream_if m_rx_if ();

    // Plain ports onto the edge streams.
    assign s_tx_if.tdata  = s_tx_data;
    assign s_tx_if.tvalid = s_tx_valid;
    assign s_tx_if.tlast  = s_tx_last;
    assign s_tx_if.tuser  = s_tx_user;
    assign s_tx_ready     = s_tx_if.tready;

    assign m_rx_data      = m_rx_if.tdata;
    assign m_rx_valid     = m_rx_if.tvalid;
    assign m_rx_last      = m_rx_if.tlast;
    assign m_rx_user      = m_rx_if.tuser;
    assign m_rx_if.tready = m_rx_ready;

    frame_fifo #(.DEPTH(TX_FIFO_DEPTH)) tx_fifo (
        .logic_clk(logic_clk), .logic_rst(logic_rst),
        .s(s_tx_if), .m(s_tx_fifo_out),
        .status_overflow(tx_fifo_overflow),
        .status_bad_frame(tx_fifo_bad_frame),
        .status_good_frame(tx_fifo_good_frame)
    );

    eth_mac_tx #(.MIN_FRAME_LEN(MIN_FRAME_LEN)) eth_mac_tx_inst (
        .logic_clk(logic_clk), .logic_rst(logic_rst),
        .s(s_tx_fifo_out),
        .cfg_ifg(cfg_ifg), .cfg_tx_enable(cfg_tx_enable),
        .gmii_txd(gmii_txd), .gmii_tx_en(gmii_tx_en), .gmii_tx_er(gmii_tx_er)
    );

    eth_mac_rx #(.MIN_FRAME_LEN(MIN_FRAME_LEN)) eth_mac_rx_inst (
        .logic_clk(logic_clk), .logic_rst(logic_rst),
        .gmii_rxd(gmii_rxd), .gmii_rx_dv(gmii_rx_dv), .gmii_rx_er(gmii_rx_er),
        .cfg_rx_enable(cfg_rx_enable),
        .m(rx_mac_out),
        .error_bad_frame(rx_error_bad_frame),
        .error_bad_fcs(rx_error_bad_fcs)
    );

    frame_fifo #(.DEPTH(RX_FIFO_DEPTH)) rx_fifo (
        .logic_clk(logic_clk), .logic_rst(logic_rst),
        .s(rx_mac_out), .m(m_rx_if),
        .status_overflow(rx_fifo_overflow),
        .status_bad_frame(rx_fifo_bad_frame),
        .status_good_frame(rx_fifo_good_frame)
    );

endmodule

/* hw/eth_mac_rx.sv */
// Ethernet receive MAC
module eth_mac_rx
    import eth_mac_pkg::*;
#(
    parameter int MIN_FRAME_LEN = 64
) (
    input  logic       logic_clk,
    input  logic       logic_rst,
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    input  logic       cfg_rx_enable,
    byte_stream_if.src m,
    output logic       error_bad_frame,
    output logic       error_bad_fcs
);

    rx_state_t   state;
    logic [7:0]  hold [FCS_LEN];  // Holdback line so the FCS is never forwarded.
    logic [2:0]  hold_cnt;
    logic [7:0]  out_data;
    logic        out_valid;
    logic [31:0] crc;
    logic [15:0] byte_cnt;        // Bytes after the SFD, FCS included.
    logic        er_seen;
    logic        frame_end;
    logic        fcs_bad;
    logic        frame_bad;

    // The frame ends in the first cycle with rx_dv low.
    assign frame_end = (state == RX_PAYLOAD) && !gmii_rx_dv;
    assign fcs_bad   = (crc != CRC_RESIDUE);
    assign frame_bad = er_seen || (byte_cnt < 16'(MIN_FRAME_LEN));

    // The wire cannot wait, so tready is not looked at.
    assign m.tdata  = out_data;
    assign m.tvalid = out_valid;
    assign m.tlast  = out_valid && frame_end;
    assign m.tuser  = fcs_bad || frame_bad;

    assign error_bad_fcs   = frame_end && fcs_bad;
    assign error_bad_frame = frame_end && frame_bad;

    always_ff @(posedge logic_clk) begin
        if ((state == RX_PAYLOAD) && gmii_rx_dv) begin
            hold[0] <= gmii_rxd;
            for (int i = 1; i < FCS_LEN; i++) begin
                hold[i] <= hold[i-1];
            end
            out_data <= hold[FCS_LEN-1];
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state     <= RX_IDLE;
            hold_cnt  <= '0;
            out_valid <= 1'b0;
            crc       <= '1;
            byte_cnt  <= '0;
            er_seen   <= 1'b0;
        end else begin
            // Outside a frame the checkers are kept primed for the next SFD.
            if (state != RX_PAYLOAD) begin
                hold_cnt  <= '0;
                out_valid <= 1'b0;
                crc       <= '1;
                byte_cnt  <= '0;
                er_seen   <= 1'b0;
            end

            case (state)
                RX_IDLE, RX_PREAMBLE: begin
                    if (!gmii_rx_dv) begin
                        state <= RX_IDLE;
                    end else if (!cfg_rx_enable && (state == RX_IDLE)) begin
                        state <= RX_DISCARD;  // Whole frame is ignored.
                    end else if (gmii_rxd == SFD_BYTE) begin
                        state <= RX_PAYLOAD;
                    end else if (gmii_rxd == PREAMBLE_BYTE) begin
                        state <= RX_PREAMBLE;
                    end else begin
                        state <= RX_DISCARD;
                    end
                end
                RX_PAYLOAD: begin
                    if (gmii_rx_dv) begin
                        crc       <= crc32_byte(crc, gmii_rxd);
                        byte_cnt  <= (byte_cnt == '1) ? byte_cnt : byte_cnt + 16'd1;
                        er_seen   <= er_seen || gmii_rx_er;
                        out_valid <= (hold_cnt == 3'(FCS_LEN));
                        if (hold_cnt != 3'(FCS_LEN)) begin
                            hold_cnt <= hold_cnt + 3'd1;
                        end
                    end else begin
                        out_valid <= 1'b0;
                        state     <= RX_IDLE;
                    end
                end
                RX_DISCARD: begin
                    if (!gmii_rx_dv) begin
                        state <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // A frame leaves as one unbroken run of valid bytes that ends on tlast.
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        m.tvalid && !m.tlast |=> m.tvalid)
        else $error("eth_mac_rx frame ended without tlast on a valid byte");

endmodule

/* hw/eth_mac_tx.sv */
// Ethernet transmit MAC
module eth_mac_tx
    import eth_mac_pkg::*;
#(
    parameter int MIN_FRAME_LEN = 64
) (
    input  logic       logic_clk,
    input  logic       logic_rst,
    byte_stream_if.snk s,
    input  logic [7:0] cfg_ifg,
    input  logic       cfg_tx_enable,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er
);

    localparam logic [15:0] MIN_DATA_LEN = 16'(MIN_FRAME_LEN - FCS_LEN);

    tx_state_t   state;
    logic [15:0] cnt;       // Preamble, data, FCS or gap count, by state.
    logic [31:0] crc;
    logic [7:0]  ifg_low;   // Idle cycles seen before the current frame.

    // Data is only taken in PAYLOAD. The FIFO holds whole frames, so it never runs dry.
    assign s.tready   = (state == TX_PAYLOAD);
    assign gmii_tx_er = 1'b0;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= TX_IDLE;
            cnt        <= '0;
            crc        <= '1;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (cfg_tx_enable && s.tvalid) begin
                        gmii_txd   <= PREAMBLE_BYTE;
                        gmii_tx_en <= 1'b1;
                        cnt        <= 16'd1;
                        state      <= TX_PREAMBLE;
                    end
                end
                TX_PREAMBLE: begin
                    if (cnt == 16'(PREAMBLE_LEN)) begin
                        gmii_txd <= SFD_BYTE;
                        cnt      <= '0;
                        crc      <= '1;
                        state    <= TX_PAYLOAD;
                    end else begin
                        gmii_txd <= PREAMBLE_BYTE;
                        cnt      <= cnt + 16'd1;
                    end
                end
                TX_PAYLOAD: begin
                    if (s.tvalid) begin
                        gmii_txd <= s.tdata;
                        crc      <= crc32_byte(crc, s.tdata);
                        cnt      <= cnt + 16'd1;
                        if (s.tlast && (cnt + 16'd1 < MIN_DATA_LEN)) begin
                            state <= TX_PAD;
                        end else if (s.tlast) begin
                            cnt   <= '0;
                            state <= TX_FCS;
                        end
                    end
                end
                TX_PAD: begin
                    gmii_txd <= 8'h00;
                    crc      <= crc32_byte(crc, 8'h00);
                    cnt      <= cnt + 16'd1;
                    if (cnt + 16'd1 == MIN_DATA_LEN) begin
                        cnt   <= '0;
                        state <= TX_FCS;
                    end
                end
                TX_FCS: begin
                    gmii_txd <= ~crc[7:0];            // Low byte goes first.
                    crc      <= {8'h00, crc[31:8]};
                    cnt      <= cnt + 16'd1;
                    if (cnt == 16'(FCS_LEN - 1)) begin
                        cnt   <= '0;
                        state <= TX_GAP;
                    end
                end
                TX_GAP: begin
                    gmii_tx_en <= 1'b0;
                    gmii_txd   <= '0;
                    cnt        <= cnt + 16'd1;
                    if (cnt >= {8'h00, cfg_ifg}) begin
                        state <= TX_IDLE;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            ifg_low <= '1;
        end else if (gmii_tx_en) begin
            ifg_low <= '0;
        end else if (ifg_low != 8'hFF) begin
            ifg_low <= ifg_low + 8'd1;  // Saturates.
        end
    end

    assert property (@(posedge logic_clk) disable iff (logic_rst)
        $rose(gmii_tx_en) |-> (ifg_low >= cfg_ifg))
        else $error("eth_mac_tx inter-frame gap shorter than cfg_ifg");

endmodule

/* hw/frame_fifo.sv */
// Store-and-forward frame FIFO
module frame_fifo #(
    parameter int DEPTH = 256
) (
    input  logic       logic_clk,
    input  logic       logic_rst,
    byte_stream_if.snk s,
    byte_stream_if.src m,
    output logic       status_overflow,
    output logic       status_bad_frame,
    output logic       status_good_frame
);

    localparam int          AW         = $clog2(DEPTH);
    localparam logic [AW:0] FULL_LEVEL = (AW + 1)'(DEPTH);

    logic [8:0]  mem [DEPTH];     // Each entry is {tlast, tdata}.
    logic [AW:0] wr_ptr;
    logic [AW:0] wr_ptr_commit;   // End of the last good frame.
    logic [AW:0] rd_ptr;
    logic        drop_frame;      // Rest of an oversize frame is being thrown away.
    logic        full;
    logic        wr_en;
    logic        commit_now;

    assign full       = (wr_ptr - rd_ptr) == FULL_LEVEL;
    assign wr_en      = s.tvalid && !full && !drop_frame;
    assign commit_now = wr_en && s.tlast && !s.tuser;

    // The input never stalls. A frame that does not fit is dropped instead.
    assign s.tready = 1'b1;

    // Only committed bytes are visible on the output side.
    assign m.tvalid = (rd_ptr != wr_ptr_commit);
    assign m.tdata  = mem[rd_ptr[AW-1:0]][7:0];
    assign m.tlast  = mem[rd_ptr[AW-1:0]][8];
    assign m.tuser  = 1'b0;  // Bad frames never leave the FIFO.

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= {s.tlast, s.tdata};
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr            <= '0;
            wr_ptr_commit     <= '0;
            rd_ptr            <= '0;
            drop_frame        <= 1'b0;
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;
        end else begin
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;

            if (m.tvalid && m.tready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            if (wr_en) begin
                if (commit_now) begin
                    wr_ptr            <= wr_ptr + 1'b1;
                    wr_ptr_commit     <= wr_ptr + 1'b1;
                    status_good_frame <= 1'b1;
                end else if (s.tlast) begin
                    wr_ptr           <= wr_ptr_commit;  // Roll back the marked frame.
                    status_bad_frame <= 1'b1;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end else if (s.tvalid) begin
                // Full or already dropping. Roll back once, then skip to tlast.
                if (!drop_frame) begin
                    status_overflow <= 1'b1;
                    wr_ptr          <= wr_ptr_commit;
                end
                drop_frame <= !s.tlast;
            end
        end
    end

    // Read pointer stays behind the commit point.
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        (wr_ptr_commit - rd_ptr) <= FULL_LEVEL)
        else $error("frame_fifo read pointer passed the commit pointer");

    // Output is valid only while the memory still holds written bytes.
    assert property (@(posedge logic_clk) disable iff (logic_rst)
        m.tvalid |-> (wr_ptr != rd_ptr))
        else $error("frame_fifo output valid while empty");

endmodule

/* hw/byte_stream_if.sv */
// Byte stream interface
interface byte_stream_if;

    logic [7:0] tdata;
    logic       tvalid;
    logic       tready;
    logic       tlast;   // Final byte of a frame.
    logic       tuser;   // Bad frame flag, only looked at together with tlast.

    modport src (
        output tdata, tvalid, tlast, tuser,
        input  tready
    );

    modport snk (
        input  tdata, tvalid, tlast, tuser,
        output tready
    );

endinterface

/* hw/eth_mac_pkg.sv */
// Ethernet MAC shared definitions
package eth_mac_pkg;

    // ##################################################
    // State encodings
    // ##################################################

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_PAYLOAD,
        TX_PAD,
        TX_FCS,
        TX_GAP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_PAYLOAD,
        RX_DISCARD
    } rx_state_t;

    // ##################################################
    // Frame constants
    // ##################################################

    localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
    localparam logic [7:0]  SFD_BYTE      = 8'hD5;
    localparam logic [3:0]  PREAMBLE_LEN  = 4'd7;  // Bytes of 0x55 ahead of the SFD.
    localparam int          FCS_LEN       = 4;
    localparam logic [31:0] CRC_POLY      = 32'hEDB8_8320;  // Reflected form.
    localparam logic [31:0] CRC_RESIDUE   = 32'hDEBB_20E3;

    // One byte of the reflected CRC-32, LSB first as it goes on the wire.
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc, input logic [7:0] data);
        logic [31:0] c;
        c = crc ^ {24'h000000, data};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage
